// File: rtl/bridge_pkg.sv
package bridge_pkg;

    // **************************************************
    // bus widths
    // **************************************************
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int id_w   = 4;
    localparam int len_w  = 8;

    // burst and response codes
    localparam logic [1:0] axi_burst_incr  = 2'b01;
    localparam logic [1:0] axi_resp_slverr = 2'b10;

    // **************************************************
    // enums
    // **************************************************
    // read source doubles as the AXI ID
    typedef enum logic {
        src_inst = 1'b0,
        src_data = 1'b1
    } req_src_e;

    typedef enum logic [1:0] {
        rd_idle = 2'd0,
        rd_addr = 2'd1,
        rd_data = 2'd2
    } rd_state_e;

    typedef enum logic [1:0] {
        wr_idle = 2'd0,
        wr_busy = 2'd1,
        wr_resp = 2'd2
    } wr_state_e;

endpackage

// File: rtl/bridge_ifs.sv
`timescale 1ns/1ns

// arbiter to read engine
interface rd_req_if import bridge_pkg::*; ();
    logic              valid;
    req_src_e          src;
    logic [addr_w-1:0] addr;
    logic [len_w-1:0]  len;
    logic [2:0]        size;
    logic              ready;
    logic              busy;
    logic              data_done;

    modport arb (output valid, src, addr, len, size, input ready, busy, data_done);
    modport eng (input valid, src, addr, len, size, output ready, busy, data_done);
endinterface

// arbiter to write engine
interface wr_req_if import bridge_pkg::*; ();
    logic                valid;
    logic [addr_w-1:0]   addr;
    logic [2:0]          size;
    logic [data_w-1:0]   wdata;
    logic [data_w/8-1:0] wstrb;
    logic                ready;
    logic                pend_valid;
    logic [addr_w-1:0]   pend_addr;
    logic                done;

    modport arb (output valid, addr, size, wdata, wstrb, input ready, pend_valid, pend_addr, done);
    modport eng (input valid, addr, size, wdata, wstrb, output ready, pend_valid, pend_addr, done);
endinterface

// File: rtl/port_arbiter.sv
`timescale 1ns/1ns

module port_arbiter import bridge_pkg::*; #(
    parameter int line_beats = 4
) (
    input  logic                aclk,
    input  logic                aresetn,
    // instruction port
    input  logic                icache_req,
    input  logic                icache_line,
    input  logic [addr_w-1:0]   icache_addr,
    output logic                icache_addr_ok,
    // data port
    input  logic                data_req,
    input  logic                data_wr,
    input  logic [1:0]          data_size,
    input  logic [data_w/8-1:0] data_wstrb,
    input  logic [addr_w-1:0]   data_addr,
    input  logic [data_w-1:0]   data_wdata,
    output logic                data_addr_ok,
    output logic                data_data_ok,
    rd_req_if.arb               rd,
    wr_req_if.arb               wr
);

    logic             data_pend;
    logic             data_rd;
    logic             data_st;
    logic             d_conflict;
    logic             i_conflict;
    logic             rd_free;
    logic             data_go_rd;
    logic             data_go_wr;
    logic             icache_go;
    logic [len_w-1:0] line_len;

    assign line_len = len_w'(line_beats - 1);

    assign data_rd = data_req & ~data_wr;
    assign data_st = data_req & data_wr;

    // word-granular match against the store in flight
    assign d_conflict = wr.pend_valid & (wr.pend_addr[addr_w-1:2] == data_addr[addr_w-1:2]);
    assign i_conflict = wr.pend_valid & (wr.pend_addr[addr_w-1:2] == icache_addr[addr_w-1:2]);

    assign rd_free = rd.ready & ~rd.busy;

    // **************************************************
    // grant
    // **************************************************
    // loads win over fetches
    assign data_go_rd = data_rd & ~data_pend & ~d_conflict & rd_free;
    assign data_go_wr = data_st & ~data_pend & wr.ready;
    assign icache_go  = icache_req & ~data_go_rd & ~i_conflict & rd_free;

    assign data_addr_ok   = data_go_rd | data_go_wr;
    assign icache_addr_ok = icache_go;

    // read request
    assign rd.valid = data_go_rd | icache_go;
    assign rd.src   = data_go_rd ? src_data : src_inst;
    assign rd.addr  = data_go_rd ? data_addr : icache_addr;
    assign rd.len   = (~data_go_rd & icache_line) ? line_len : '0;
    assign rd.size  = data_go_rd ? {1'b0, data_size} : 3'b010;

    // store request
    assign wr.valid = data_go_wr;
    assign wr.addr  = data_addr;
    assign wr.size  = {1'b0, data_size};
    assign wr.wdata = data_wdata;
    assign wr.wstrb = data_wstrb;

    // **************************************************
    // data port completion
    // **************************************************
    assign data_data_ok = rd.data_done | wr.done;

    // one data op in flight
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            data_pend <= 1'b0;
        end else if (data_addr_ok) begin
            data_pend <= 1'b1;
        end else if (data_data_ok) begin
            data_pend <= 1'b0;
        end
    end

endmodule

// File: rtl/axi_read_engine.sv
`timescale 1ns/1ns

module axi_read_engine import bridge_pkg::*; #(
    parameter int line_beats = 4
) (
    input  logic              aclk,
    input  logic              aresetn,
    rd_req_if.eng             rd,
    // AR channel
    output logic [id_w-1:0]   arid,
    output logic [addr_w-1:0] araddr,
    output logic [len_w-1:0]  arlen,
    output logic [2:0]        arsize,
    output logic [1:0]        arburst,
    output logic              arvalid,
    input  logic              arready,
    // R channel
    input  logic [id_w-1:0]   rid,
    input  logic [data_w-1:0] rdata,
    input  logic [1:0]        rresp,
    input  logic              rlast,
    input  logic              rvalid,
    output logic              rready,
    // return paths
    output logic              icache_ret_valid,
    output logic              icache_ret_last,
    output logic [data_w-1:0] icache_ret_data,
    output logic [data_w-1:0] data_rdata
);

    localparam int cnt_w = (line_beats > 1) ? $clog2(line_beats) : 1;

    rd_state_e         state;
    logic [cnt_w-1:0]  beat_cnt;
    logic              r_hs;
    logic              beat_last;
    logic              beat_is_data;
    logic [data_w-1:0] beat_data;
    logic              data_done_q;

    assign arvalid = (state == rd_addr);
    assign rready  = (state == rd_data);
    assign arburst = axi_burst_incr;

    assign r_hs         = rvalid & rready;
    assign beat_is_data = (rid == id_w'(src_data));
    // burst also closes on the expected beat count
    assign beat_last    = rlast | (len_w'(beat_cnt) == arlen);
    // error beats come back as zero
    assign beat_data    = rresp[1] ? '0 : rdata;

    assign rd.ready     = (state == rd_idle);
    assign rd.busy      = (state != rd_idle) | icache_ret_valid | data_done_q;
    assign rd.data_done = data_done_q;

    // **************************************************
    // read FSM
    // **************************************************
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= rd_idle;
        end else begin
            case (state)
                rd_idle: if (rd.valid & rd.ready) state <= rd_addr;
                rd_addr: if (arready) state <= rd_data;
                rd_data: if (r_hs & beat_last) state <= rd_idle;
                default: state <= rd_idle;
            endcase
        end
    end

    // AR payload, held until the next accept
    always_ff @(posedge aclk) begin
        if (rd.valid & rd.ready) begin
            arid   <= id_w'(rd.src);
            araddr <= rd.addr;
            arlen  <= rd.len;
            arsize <= rd.size;
        end
    end

    always_ff @(posedge aclk) begin
        if (rd.valid & rd.ready) begin
            beat_cnt <= '0;
        end else if (r_hs) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // **************************************************
    // return routing
    // **************************************************
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            icache_ret_valid <= 1'b0;
            data_done_q      <= 1'b0;
        end else begin
            icache_ret_valid <= r_hs & ~beat_is_data;
            data_done_q      <= r_hs & beat_is_data & beat_last;
        end
    end

    always_ff @(posedge aclk) begin
        if (r_hs & ~beat_is_data) begin
            icache_ret_data <= beat_data;
            icache_ret_last <= beat_last;
        end
        if (r_hs & beat_is_data) begin
            data_rdata <= beat_data;
        end
    end

endmodule

// File: rtl/axi_write_engine.sv
`timescale 1ns/1ns

module axi_write_engine import bridge_pkg::*; (
    input  logic                aclk,
    input  logic                aresetn,
    wr_req_if.eng               wr,
    // AW channel
    output logic [id_w-1:0]     awid,
    output logic [addr_w-1:0]   awaddr,
    output logic [len_w-1:0]    awlen,
    output logic [2:0]          awsize,
    output logic [1:0]          awburst,
    output logic                awvalid,
    input  logic                awready,
    // W channel
    output logic [data_w-1:0]   wdata_o,
    output logic [data_w/8-1:0] wstrb_o,
    output logic                wlast,
    output logic                wvalid,
    input  logic                wready,
    // B channel
    input  logic [id_w-1:0]     bid,
    input  logic [1:0]          bresp,
    input  logic                bvalid,
    output logic                bready
);

    wr_state_e state;
    logic      aw_done;
    logic      w_done;
    logic      aw_hs;
    logic      w_hs;
    logic      b_hs;
    logic      b_retry;

    // single-beat stores only
    assign awid    = id_w'(src_data);
    assign awlen   = '0;
    assign awburst = axi_burst_incr;
    assign wlast   = 1'b1;

    assign awvalid = (state == wr_busy) & ~aw_done;
    assign wvalid  = (state == wr_busy) & ~w_done;
    assign bready  = (state == wr_resp);

    assign aw_hs   = awvalid & awready;
    assign w_hs    = wvalid & wready;
    // responses with a foreign ID are dropped
    assign b_hs    = bvalid & bready & (bid == awid);
    // slave error replays the store
    assign b_retry = (bresp == axi_resp_slverr);

    assign wr.ready      = (state == wr_idle);
    assign wr.pend_valid = (state != wr_idle) | (wr.valid & wr.ready);
    assign wr.pend_addr  = (state == wr_idle) ? wr.addr : awaddr;
    assign wr.done       = b_hs & ~b_retry;

    // **************************************************
    // write FSM
    // **************************************************
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state   <= wr_idle;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                wr_idle: begin
                    if (wr.valid & wr.ready) begin
                        state   <= wr_busy;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end
                end
                wr_busy: begin
                    // AW and W finish in any order
                    if ((aw_done | aw_hs) & (w_done | w_hs)) state <= wr_resp;
                    if (aw_hs) aw_done <= 1'b1;
                    if (w_hs) w_done <= 1'b1;
                end
                wr_resp: begin
                    if (b_hs & b_retry) begin
                        state   <= wr_busy;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end else if (b_hs) begin
                        state <= wr_idle;
                    end
                end
                default: state <= wr_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (wr.valid & wr.ready) begin
            awaddr  <= wr.addr;
            awsize  <= wr.size;
            wdata_o <= wr.wdata;
            wstrb_o <= wr.wstrb;
        end
    end

endmodule

// File: rtl/cpu_axi_bridge.sv
`timescale 1ns/1ns

module cpu_axi_bridge import bridge_pkg::*; #(
    parameter int line_beats = 4
) (
    input  logic                aclk,
    input  logic                aresetn,
    // instruction port
    input  logic                icache_req,
    input  logic                icache_line,
    input  logic [addr_w-1:0]   icache_addr,
    output logic                icache_addr_ok,
    output logic                icache_ret_valid,
    output logic                icache_ret_last,
    output logic [data_w-1:0]   icache_ret_data,
    // data port
    input  logic                data_req,
    input  logic                data_wr,
    input  logic [1:0]          data_size,
    input  logic [data_w/8-1:0] data_wstrb,
    input  logic [addr_w-1:0]   data_addr,
    input  logic [data_w-1:0]   data_wdata,
    output logic                data_addr_ok,
    output logic                data_data_ok,
    output logic [data_w-1:0]   data_rdata,
    // AR
    output logic [id_w-1:0]     arid,
    output logic [addr_w-1:0]   araddr,
    output logic [len_w-1:0]    arlen,
    output logic [2:0]          arsize,
    output logic [1:0]          arburst,
    output logic [1:0]          arlock,
    output logic [3:0]          arcache,
    output logic [2:0]          arprot,
    output logic                arvalid,
    input  logic                arready,
    // R
    input  logic [id_w-1:0]     rid,
    input  logic [data_w-1:0]   rdata,
    input  logic [1:0]          rresp,
    input  logic                rlast,
    input  logic                rvalid,
    output logic                rready,
    // AW
    output logic [id_w-1:0]     awid,
    output logic [addr_w-1:0]   awaddr,
    output logic [len_w-1:0]    awlen,
    output logic [2:0]          awsize,
    output logic [1:0]          awburst,
    output logic [1:0]          awlock,
    output logic [3:0]          awcache,
    output logic [2:0]          awprot,
    output logic                awvalid,
    input  logic                awready,
    // W
    output logic [id_w-1:0]     wid,
    output logic [data_w-1:0]   wdata,
    output logic [data_w/8-1:0] wstrb,
    output logic                wlast,
    output logic                wvalid,
    input  logic                wready,
    // B
    input  logic [id_w-1:0]     bid,
    input  logic [1:0]          bresp,
    input  logic                bvalid,
    output logic                bready
);

    rd_req_if rd_bus ();
    wr_req_if wr_bus ();

    // plain, non-cacheable, unprivileged accesses
    assign arlock  = 2'b00;
    assign arcache = 4'b0000;
    assign arprot  = 3'b000;
    assign awlock  = 2'b00;
    assign awcache = 4'b0000;
    assign awprot  = 3'b000;
    assign wid     = awid;

    port_arbiter #(.line_beats(line_beats)) u_arb (
        .aclk, .aresetn,
        .icache_req, .icache_line, .icache_addr, .icache_addr_ok,
        .data_req, .data_wr, .data_size, .data_wstrb, .data_addr, .data_wdata,
        .data_addr_ok, .data_data_ok,
        .rd (rd_bus.arb),
        .wr (wr_bus.arb)
    );

    axi_read_engine #(.line_beats(line_beats)) u_rd (
        .aclk, .aresetn,
        .rd (rd_bus.eng),
        .arid, .araddr, .arlen, .arsize, .arburst, .arvalid, .arready,
        .rid, .rdata, .rresp, .rlast, .rvalid, .rready,
        .icache_ret_valid, .icache_ret_last, .icache_ret_data, .data_rdata
    );

    axi_write_engine u_wr (
        .aclk, .aresetn,
        .wr (wr_bus.eng),
        .awid, .awaddr, .awlen, .awsize, .awburst, .awvalid, .awready,
        .wdata_o (wdata),
        .wstrb_o (wstrb),
        .wlast, .wvalid, .wready,
        .bid, .bresp, .bvalid, .bready
    );

endmodule

// File: test/axi_slave_mem.sv
`timescale 1ns/1ns

module axi_slave_mem (
    input  logic        aclk,
    input  logic        aresetn,
    // AR and R
    input  logic [3:0]  arid,
    input  logic [31:0] araddr,
    input  logic [7:0]  arlen,
    input  logic        arvalid,
    output logic        arready,
    output logic [3:0]  rid,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready,
    // AW, W and B
    input  logic [3:0]  awid,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [3:0]  bid,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready
);

    logic [31:0] mem [0:4095];
    logic [31:0] lfsr;
    logic [1:0]  dly;
    logic [1:0]  ar_wait;
    logic [1:0]  r_wait;
    logic [1:0]  aw_wait;
    logic [1:0]  w_wait;
    logic [1:0]  b_wait;
    logic        r_busy;
    logic        aw_got;
    logic        w_got;
    logic [31:0] r_addr;
    logic [7:0]  r_left;
    logic [3:0]  r_id;
    logic [31:0] aw_addr_q;
    logic [3:0]  aw_id_q;
    logic [31:0] w_data_q;
    logic [3:0]  w_strb_q;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // two random bits, one step each
    task automatic draw_delay(output logic [1:0] d);
        d = {1'b0, lfsr[0]};
        lfsr = lfsr_next(lfsr);
        d = {d[0], lfsr[0]};
        lfsr = lfsr_next(lfsr);
    endtask

    // word at byte address A holds A xor 5a5a0000
    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[i] <= 32'(i * 4) ^ 32'h5a5a0000;
        end
        arready <= 1'b0;
        rvalid  <= 1'b0;
        rlast   <= 1'b0;
        rid     <= '0;
        rdata   <= '0;
        rresp   <= 2'b00;
        awready <= 1'b0;
        wready  <= 1'b0;
        bvalid  <= 1'b0;
        bid     <= '0;
        bresp   <= 2'b00;
    end

    always @(posedge aclk) begin
        if (!aresetn) begin
            lfsr = 32'he7b4;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            r_busy  <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            ar_wait <= '0;
            r_wait  <= '0;
            aw_wait <= '0;
            w_wait  <= '0;
            b_wait  <= '0;
        end else begin
            // **************************************************
            // read side, one burst at a time
            // **************************************************
            if (arvalid && arready) begin
                arready <= 1'b0;
                r_busy  <= 1'b1;
                r_addr  <= araddr;
                r_left  <= arlen;
                r_id    <= arid;
                draw_delay(dly);
                r_wait <= dly;
                draw_delay(dly);
                ar_wait <= dly;
            end else if (arvalid && !r_busy) begin
                if (ar_wait == 2'd0) arready <= 1'b1;
                else ar_wait <= ar_wait - 2'd1;
            end

            if (rvalid && rready) begin
                rvalid <= 1'b0;
                rlast  <= 1'b0;
                if (r_left == 8'd0) begin
                    r_busy <= 1'b0;
                end else begin
                    r_left <= r_left - 8'd1;
                    r_addr <= r_addr + 32'd4;
                    draw_delay(dly);
                    r_wait <= dly;
                end
            end else if (r_busy && !rvalid) begin
                if (r_wait == 2'd0) begin
                    rvalid <= 1'b1;
                    rid    <= r_id;
                    rdata  <= mem[r_addr[13:2]];
                    rresp  <= 2'b00;
                    rlast  <= (r_left == 8'd0);
                end else begin
                    r_wait <= r_wait - 2'd1;
                end
            end

            // **************************************************
            // write side
            // **************************************************
            if (awvalid && awready) begin
                awready   <= 1'b0;
                aw_got    <= 1'b1;
                aw_addr_q <= awaddr;
                aw_id_q   <= awid;
                draw_delay(dly);
                aw_wait <= dly;
            end else if (awvalid && !aw_got) begin
                if (aw_wait == 2'd0) awready <= 1'b1;
                else aw_wait <= aw_wait - 2'd1;
            end

            if (wvalid && wready) begin
                wready   <= 1'b0;
                w_got    <= 1'b1;
                w_data_q <= wdata;
                w_strb_q <= wstrb;
                draw_delay(dly);
                w_wait <= dly;
            end else if (wvalid && !w_got) begin
                if (w_wait == 2'd0) wready <= 1'b1;
                else w_wait <= w_wait - 2'd1;
            end

            // memory takes the bytes as the response goes out
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                draw_delay(dly);
                b_wait <= dly;
            end else if (aw_got && w_got && !bvalid) begin
                if (b_wait == 2'd0) begin
                    for (int b = 0; b < 4; b++) begin
                        if (w_strb_q[b]) mem[aw_addr_q[13:2]][8*b +: 8] <= w_data_q[8*b +: 8];
                    end
                    bvalid <= 1'b1;
                    bid    <= aw_id_q;
                    bresp  <= 2'b00;
                end else begin
                    b_wait <= b_wait - 2'd1;
                end
            end
        end
    end

endmodule

// File: test/tb_cpu_axi_bridge.sv
`timescale 1ns/1ns

module tb_cpu_axi_bridge;

    localparam int line_beats = 4;
    localparam int max_tests  = 32;

    logic        aclk;
    logic        aresetn;
    // CPU side
    logic        icache_req;
    logic        icache_line;
    logic [31:0] icache_addr;
    logic        icache_addr_ok;
    logic        icache_ret_valid;
    logic        icache_ret_last;
    logic [31:0] icache_ret_data;
    logic        data_req;
    logic        data_wr;
    logic [1:0]  data_size;
    logic [3:0]  data_wstrb;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic        data_addr_ok;
    logic        data_data_ok;
    logic [31:0] data_rdata;
    // AXI side
    logic [3:0]  arid, rid, awid, wid, bid;
    logic [31:0] araddr, rdata, awaddr, wdata;
    logic [7:0]  arlen, awlen;
    logic [2:0]  arsize, awsize, arprot, awprot;
    logic [1:0]  arburst, awburst, arlock, awlock, rresp, bresp;
    logic [3:0]  arcache, awcache, wstrb;
    logic        arvalid, arready, rlast, rvalid, rready;
    logic        awvalid, awready, wlast, wvalid, wready, bvalid, bready;

    // test table
    logic [8*16-1:0] names  [max_tests];
    logic [8*8-1:0]  ops    [max_tests];
    logic [31:0]     addrs  [max_tests];
    logic [31:0]     wdatas [max_tests];
    logic [3:0]      wstrbs [max_tests];
    logic [1:0]      sizes  [max_tests];
    logic [31:0]     exps   [max_tests];
    int              n_tests;
    logic            loaded;
    int              ok_count = 0;
    logic [7:0]      last_arlen;
    logic [1:0]      last_arburst;
    logic [2:0]      last_arsize;
    logic [2:0]      last_awsize;

    cpu_axi_bridge #(.line_beats(line_beats)) dut0 (.*);

    axi_slave_mem mem0 (.*);

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    // data results and AXI payloads, seen at the clock edge
    always @(posedge aclk) begin
        if (data_data_ok) ok_count <= ok_count + 1;
        if (arvalid && arready) begin
            last_arlen   <= arlen;
            last_arburst <= arburst;
            last_arsize  <= arsize;
            compare("ar attrs", 32'd0, 32'({arlock, arcache, arprot}));
        end
        if (awvalid && awready) begin
            last_awsize <= awsize;
            compare("aw id", 32'd1, 32'(awid));
            compare("aw len", 32'd0, 32'(awlen));
            compare("aw burst", 32'h1, 32'(awburst));
            compare("aw attrs", 32'd0, 32'({awlock, awcache, awprot}));
        end
        if (wvalid && wready) begin
            compare("w id", 32'd1, 32'(wid));
            compare("w last", 32'd1, 32'(wlast));
        end
    end

    // **************************************************
    // checker and helpers
    // **************************************************
    task automatic compare(input logic [127:0] name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %0s expected %h actual %h", name, expected, actual);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] preload_word(input logic [31:0] addr);
        return addr ^ 32'h5a5a0000;
    endfunction

    task automatic issue_fetch(input logic [31:0] addr, input logic line);
        @(posedge aclk);
        icache_req  <= 1'b1;
        icache_line <= line;
        icache_addr <= addr;
        do @(negedge aclk); while (!icache_addr_ok);
        @(posedge aclk);
        icache_req <= 1'b0;
    endtask

    task automatic fetch_word(input logic [127:0] name, input logic [31:0] addr,
                              input logic [31:0] exp);
        issue_fetch(addr, 1'b0);
        do @(negedge aclk); while (!icache_ret_valid);
        compare(name, exp, icache_ret_data);
        compare(name, 32'd1, 32'(icache_ret_last));
        compare(name, 32'd0, 32'(last_arlen));
        compare(name, 32'd2, 32'(last_arsize));
    endtask

    // first word from the table, the rest from the fill rule
    task automatic fetch_line(input logic [127:0] name, input logic [31:0] addr,
                              input logic [31:0] exp);
        int k;
        logic [31:0] want;
        issue_fetch(addr, 1'b1);
        k = 0;
        while (k < line_beats) begin
            @(negedge aclk);
            if (icache_ret_valid) begin
                want = (k == 0) ? exp : preload_word(addr + 32'(4 * k));
                compare(name, want, icache_ret_data);
                compare(name, 32'(k == line_beats - 1), 32'(icache_ret_last));
                k++;
            end
        end
        compare(name, 32'(line_beats - 1), 32'(last_arlen));
        compare(name, 32'h1, 32'(last_arburst));
        compare(name, 32'd2, 32'(last_arsize));
        repeat (4) begin
            @(negedge aclk);
            compare(name, 32'd0, 32'(icache_ret_valid));
        end
    endtask

    task automatic data_access(input logic [127:0] name, input logic wr,
                               input logic [31:0] addr, input logic [31:0] wdat,
                               input logic [3:0] strb, input logic [1:0] size,
                               input logic [31:0] exp);
        int start;
        start = ok_count;
        @(posedge aclk);
        data_req   <= 1'b1;
        data_wr    <= wr;
        data_addr  <= addr;
        data_wdata <= wdat;
        data_wstrb <= strb;
        data_size  <= size;
        do @(negedge aclk); while (!data_addr_ok);
        @(posedge aclk);
        data_req <= 1'b0;
        do @(negedge aclk); while (!data_data_ok);
        if (wr) begin
            compare(name, 32'(size), 32'(last_awsize));
        end else begin
            compare(name, exp, data_rdata);
            compare(name, 32'(size), 32'(last_arsize));
        end
        // exactly one result pulse
        repeat (3) @(negedge aclk);
        compare(name, 32'(start + 1), 32'(ok_count));
    endtask

    task automatic dual_read(input logic [127:0] name, input logic [31:0] daddr,
                             input logic [31:0] iaddr, input logic [1:0] size,
                             input logic [31:0] exp);
        @(posedge aclk);
        data_req    <= 1'b1;
        data_wr     <= 1'b0;
        data_addr   <= daddr;
        data_size   <= size;
        icache_req  <= 1'b1;
        icache_line <= 1'b0;
        icache_addr <= iaddr;
        // load wins the shared read channel
        @(negedge aclk);
        compare(name, 32'd1, 32'(data_addr_ok));
        compare(name, 32'd0, 32'(icache_addr_ok));
        @(posedge aclk);
        data_req <= 1'b0;
        do @(negedge aclk); while (!data_data_ok);
        compare(name, exp, data_rdata);
        compare(name, 32'(size), 32'(last_arsize));
        do @(negedge aclk); while (!icache_addr_ok);
        @(posedge aclk);
        icache_req <= 1'b0;
        do @(negedge aclk); while (!icache_ret_valid);
        compare(name, preload_word(iaddr), icache_ret_data);
        compare(name, 32'd1, 32'(icache_ret_last));
        compare(name, 32'd2, 32'(last_arsize));
    endtask

    // **************************************************
    // main sequence
    // **************************************************
    initial begin
        int fd;
        int cnt;
        logic [8*16-1:0]  tok;
        logic [8*100-1:0] rest;
        loaded = 1'b0;
        n_tests = 0;
        aresetn     <= 1'b0;
        icache_req  <= 1'b0;
        icache_line <= 1'b0;
        icache_addr <= '0;
        data_req    <= 1'b0;
        data_wr     <= 1'b0;
        data_size   <= '0;
        data_wstrb  <= '0;
        data_addr   <= '0;
        data_wdata  <= '0;

        fd = $fopen("test/bridge_tests.txt", "r");
        if (fd == 0) begin
            $display("the test file test/bridge_tests.txt could not be opened");
            $display("Verification failed");
            $fatal(1);
        end
        while (!$feof(fd) && n_tests < max_tests) begin
            cnt = $fscanf(fd, "%s", tok);
            if (cnt == 1) begin
                if (tok == "#") begin
                    cnt = $fgets(rest, fd);
                end else begin
                    names[n_tests] = tok;
                    cnt = $fscanf(fd, "%s %h %h %h %d %h", ops[n_tests], addrs[n_tests],
                                  wdatas[n_tests], wstrbs[n_tests], sizes[n_tests],
                                  exps[n_tests]);
                    if (cnt != 6) begin
                        $display("the test file line for %0s is malformed", tok);
                        $display("Verification failed");
                        $fatal(1);
                    end
                    n_tests++;
                end
            end
        end
        $fclose(fd);
        loaded = 1'b1;

        repeat (8) @(posedge aclk);
        aresetn <= 1'b1;
        @(negedge aclk);
        compare("reset", 32'd0, 32'(arvalid));
        compare("reset", 32'd0, 32'(awvalid));
        compare("reset", 32'd0, 32'(wvalid));
        compare("reset", 32'd0, 32'(rready));
        compare("reset", 32'd0, 32'(bready));
        compare("reset", 32'd0, 32'(icache_ret_valid));
        compare("reset", 32'd0, 32'(data_data_ok));
        compare("reset", 32'd0, 32'(icache_addr_ok));
        compare("reset", 32'd0, 32'(data_addr_ok));

        for (int i = 0; i < n_tests; i++) begin
            case (ops[i])
                "ifetch": fetch_word(names[i], addrs[i], exps[i]);
                "iline":  fetch_line(names[i], addrs[i], exps[i]);
                "load":   data_access(names[i], 1'b0, addrs[i], wdatas[i], wstrbs[i],
                                      sizes[i], exps[i]);
                "store":  data_access(names[i], 1'b1, addrs[i], wdatas[i], wstrbs[i],
                                      sizes[i], exps[i]);
                "dual":   dual_read(names[i], addrs[i], wdatas[i], sizes[i], exps[i]);
                default: begin
                    $display("test %0s names an unknown operation", names[i]);
                    $display("Verification failed");
                    $fatal(1);
                end
            endcase
        end

        $display("Verification passed");
        $finish;
    end

    // watchdog sized from the number of tests
    initial begin
        wait (loaded);
        #((n_tests * 40 + 100) * 4);
        $display("the run timed out before all tests had finished");
        $display("Verification failed");
        $fatal(1);
    end

endmodule

// File: test/bridge_tests.txt
# name op addr wdata wstrb size expected
# for dual the wdata column holds the fetch address
fetch0 ifetch 00000100 00000000 0 2 5a5a0100
fetch1 ifetch 00000204 00000000 0 2 5a5a0204
line0 iline 00000400 00000000 0 2 5a5a0400
load0 load 00000800 00000000 0 2 5a5a0800
store0 store 00000800 11223344 3 2 00000000
load1 load 00000800 00000000 0 2 5a5a3344
store1 store 00000c0c aabbccdd c 2 00000000
load2 load 00000c0c 00000000 0 2 aabb0c0c
dual0 dual 00000a00 00000110 0 2 5a5a0a00
store2 store 00001000 deadbeef f 2 00000000
load3 load 00001000 00000000 0 2 deadbeef
line1 iline 00001040 00000000 0 2 5a5a1040
store3 store 00000400 00000077 1 2 00000000
line2 iline 00000400 00000000 0 2 5a5a0477
dual1 dual 00000c0c 00000804 0 2 aabb0c0c
load4 load 00003ffc 00000000 0 2 5a5a3ffc
fetch2 ifetch 00003ff8 00000000 0 2 5a5a3ff8
store4 store 00003ffc 01020304 6 2 00000000
load5 load 00003ffc 00000000 0 2 5a0203fc

// File: tb.f
rtl/bridge_pkg.sv
rtl/bridge_ifs.sv
rtl/port_arbiter.sv
rtl/axi_read_engine.sv
rtl/axi_write_engine.sv
rtl/cpu_axi_bridge.sv
test/axi_slave_mem.sv
test/tb_cpu_axi_bridge.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_cpu_axi_bridge -f tb.f -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Verification failed" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation FAILED, see sim.log"
    exit 1
fi
echo "simulation ok"
